// ==== exec_backend.f ====
verilog/exec_ops_pkg.sv
verilog/pipe_types_pkg.sv
verilog/forwarding_unit.sv
verilog/alu.sv
verilog/mdu.sv
verilog/stall_ctrl.sv
verilog/backend_pipeline.sv
verilog/exec_backend.sv
verification/tb_exec_backend.sv

// ==== Makefile ====
TOP = tb_exec_backend

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f exec_backend.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module exec_backend -f exec_backend.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== verification/tb_exec_backend.sv ====
`timescale 1ns/1ps

module tb_exec_backend;
	import exec_ops_pkg::*;
	import pipe_types_pkg::*;

	localparam int MDU_CYCLES = 4;
	localparam int TIMEOUT = 60; // cycles allowed per wait

	typedef struct packed {
		logic [4:0]      rd;
		logic [XLEN-1:0] val;
		logic [XLEN-1:0] old; // shadow value before this write
	} wb_exp_t;

	logic            clk = 1'b0;
	logic            rst_n;
	logic            issue;
	ctrl_flow_t      ctrl_flow;
	data_flow_t      data_flow;
	logic            flush;
	logic            issue_ready;
	logic            reg_w_en;
	logic [4:0]      reg_w_addr;
	logic [XLEN-1:0] reg_w_data;

	logic [XLEN-1:0] shadow [32];
	wb_exp_t         exp_q [$];
	logic [4:0]      occ_rd [3];  // ex, m1, m2 as the issuer sees them with zero for a bubble
	logic            occ_mul [3];
	int              err_cnt;
	int              wb_cnt;
	int              timeout_cnt;
	logic [31:0]     pc;

	always #5 clk = ~clk;

	exec_backend #(.MDU_CYCLES(MDU_CYCLES)) UUT (
		.clk, .rst_n,
		.issue_i       (issue),
		.ctrl_flow_i   (ctrl_flow),
		.data_flow_i   (data_flow),
		.flush_i       (flush),
		.issue_ready_o (issue_ready),
		.reg_w_en_o    (reg_w_en),
		.reg_w_addr_o  (reg_w_addr),
		.reg_w_data_o  (reg_w_data)
	);

	function automatic logic [XLEN-1:0] alu_ref(input alu_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b);
		case (op)
			ALU_ADD:   return a + b;
			ALU_SUB:   return a - b;
			ALU_AND:   return a & b;
			ALU_OR:    return a | b;
			ALU_XOR:   return a ^ b;
			ALU_SLL:   return a << b[4:0];
			ALU_SRL:   return a >> b[4:0];
			ALU_SLT:   return {31'b0, $signed(a) < $signed(b)};
			ALU_PASSB: return b;
			default:   return '0;
		endcase
	endfunction

	// where the operand sits once the consumer is in ex
	function automatic logic [3:0] pick_src(input logic [4:0] rs);
		if (rs == 5'd0) return 4'b0001;
		if (occ_rd[0] == rs) return 4'b0010; // m1
		if (occ_rd[1] == rs) return 4'b0100; // m2
		if (occ_rd[2] == rs) return 4'b1000; // wb
		return 4'b0001;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic end_run();
		$display("write-backs %0d, errors %0d, timeouts %0d, missing %0d",
			wb_cnt, err_cnt, timeout_cnt, exp_q.size());
		if (err_cnt == 0 && timeout_cnt == 0 && exp_q.size() == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	endtask

	// the whole pipe moves only when ex is free
	task automatic shift_model(input logic [4:0] rd, input logic mul, input logic fl);
		if (issue_ready) begin
			occ_rd[2] = fl ? 5'd0 : occ_rd[1];
			occ_mul[2] = fl ? 1'b0 : occ_mul[1];
			occ_rd[1] = fl ? 5'd0 : occ_rd[0];
			occ_mul[1] = fl ? 1'b0 : occ_mul[0];
			occ_rd[0] = rd;
			occ_mul[0] = mul;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			shift_model(5'd0, 1'b0, 1'b0);
			tick();
		end
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!issue_ready && n < TIMEOUT) begin
			idle(1);
			n++;
		end
		if (!issue_ready) begin
			$display("timeout: issue_ready_o stayed low for %0d cycles", TIMEOUT);
			timeout_cnt++;
		end
	endtask

	task automatic send(input alu_op_e op, input logic mul, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2);
		ctrl_flow_t      c;
		data_flow_t      d;
		wb_exp_t         e;
		logic [3:0]      s1;
		logic [3:0]      s2;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		wait_ready();
		// product exists from m2 on and the MDU takes one multiply at a time
		if (occ_mul[0] && (mul || occ_rd[0] == rs1 || occ_rd[0] == rs2)) begin
			idle(1);
			wait_ready();
		end
		s1 = pick_src(rs1);
		s2 = pick_src(rs2);
		a = shadow[rs1];
		b = shadow[rs2];
		c = '0;
		c.valid = 1'b1;
		c.alu_op = op;
		c.wb_sel = mul ? WB_MDU : WB_ALU;
		c.mul_en = mul;
		c.w_reg = rd;
		c.fwd[0] = '{ex_src: s1, m1_src: 3'b001, m2_src: 2'b01};
		c.fwd[1] = '{ex_src: s2, m1_src: 3'b001, m2_src: 2'b01};
		d.pc = pc;
		d.reg_data[0] = s1[0] ? a : ~a; // stale copy so a missed forward shows
		d.reg_data[1] = s2[0] ? b : ~b;
		d.result = '0;
		e.rd = rd;
		e.val = mul ? a * b : alu_ref(op, a, b);
		e.old = shadow[rd];
		exp_q.push_back(e);
		shadow[rd] = e.val;
		issue = 1'b1;
		ctrl_flow = c;
		data_flow = d;
		shift_model(rd, mul, 1'b0);
		tick();
		issue = 1'b0;
		pc = pc + 32'd4;
	endtask

	// kills ex and m1 and undoes their shadow writes youngest first
	task automatic flush_pipe();
		wb_exp_t e;
		int      kill;
		wait_ready();
		kill = int'(occ_rd[0] != 5'd0) + int'(occ_rd[1] != 5'd0);
		repeat (kill) begin
			e = exp_q.pop_back();
			shadow[e.rd] = e.old;
		end
		flush = 1'b1;
		shift_model(5'd0, 1'b0, 1'b1);
		tick();
		flush = 1'b0;
	endtask

	task automatic measure_stall();
		int n;
		int low;
		n = 0;
		low = 0;
		while (issue_ready && n < TIMEOUT) begin
			idle(1);
			n++;
		end
		while (!issue_ready && n < TIMEOUT) begin
			idle(1);
			n++;
			low++;
		end
		if (n >= TIMEOUT) begin
			$display("timeout: no multiply stall seen within %0d cycles", TIMEOUT);
			timeout_cnt++;
		end else begin
			assert (low == MDU_CYCLES - 2) else begin
				err_cnt++;
				$display("[FAIL] %0t multiply held m2 for %0d cycles, expected %0d",
					$realtime, low, MDU_CYCLES - 2);
			end
		end
	endtask

	// write-backs retire in issue order
	always @(negedge clk) begin
		if (rst_n && reg_w_en) begin
			wb_cnt++;
			assert (exp_q.size() > 0) else begin
				err_cnt++;
				$display("[FAIL] %0t write-back to r%0d with none expected", $realtime, reg_w_addr);
			end
			if (exp_q.size() > 0) begin
				assert (reg_w_addr == exp_q[0].rd && reg_w_data == exp_q[0].val) else begin
					err_cnt++;
					$display("[FAIL] %0t got r%0d = %h, expected r%0d = %h", $realtime,
						reg_w_addr, reg_w_data, exp_q[0].rd, exp_q[0].val);
				end
				void'(exp_q.pop_front());
			end
		end
	end

	initial begin
		int         n;
		logic [4:0] rd;
		$timeformat(-9, 0, " ns", 0);
		void'($urandom(32'h4e10));
		rst_n = 1'b0;
		issue = 1'b0;
		flush = 1'b0;
		ctrl_flow = '0;
		data_flow = '0;
		err_cnt = 0;
		wb_cnt = 0;
		timeout_cnt = 0;
		pc = 32'h0000_1000;
		shadow[0] = '0;
		for (int i = 1; i < 32; i++) shadow[i] = $urandom;
		for (int i = 0; i < 3; i++) begin
			occ_rd[i] = 5'd0;
			occ_mul[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (6) begin // idle pipe stays ready and silent
			assert (issue_ready) else begin
				err_cnt++;
				$display("[FAIL] %0t issue_ready_o low on an idle pipe", $realtime);
			end
			tick();
		end
		for (int i = 0; i < 9; i++) begin
			send(alu_op_e'(i), 1'b0, 5'(i + 1), 5'(20 + i), 5'(31 - i)); // independent ops
		end
		send(ALU_ADD, 1'b0, 5'd10, 5'd20, 5'd21); // chain through m1, m2, wb
		send(ALU_SUB, 1'b0, 5'd11, 5'd10, 5'd22);
		send(ALU_XOR, 1'b0, 5'd12, 5'd23, 5'd10);
		send(ALU_OR, 1'b0, 5'd13, 5'd10, 5'd11);
		idle(4);
		send(ALU_ADD, 1'b1, 5'd14, 5'd20, 5'd21);
		measure_stall();
		send(ALU_ADD, 1'b1, 5'd15, 5'd14, 5'd22);
		send(ALU_SUB, 1'b0, 5'd16, 5'd15, 5'd14); // reads the mul right behind it
		send(ALU_ADD, 1'b1, 5'd17, 5'd16, 5'd16);
		send(ALU_ADD, 1'b1, 5'd18, 5'd17, 5'd23); // back to back muls
		idle(4);
		send(ALU_XOR, 1'b0, 5'd3, 5'd20, 5'd21);
		send(ALU_ADD, 1'b1, 5'd4, 5'd22, 5'd23);
		send(ALU_OR, 1'b0, 5'd5, 5'd24, 5'd25);
		send(ALU_ADD, 1'b0, 5'd6, 5'd3, 5'd4); // held in ex with r3 in wb
		send(ALU_ADD, 1'b0, 5'd7, 5'd20, 5'd21);
		send(ALU_SUB, 1'b0, 5'd8, 5'd7, 5'd22);
		send(ALU_ADD, 1'b1, 5'd9, 5'd8, 5'd23);
		flush_pipe();
		send(ALU_OR, 1'b0, 5'd10, 5'd8, 5'd9); // sees the rolled back values
		for (int i = 0; i < 300; i++) begin
			n = $urandom_range(0, 99);
			if (n < 4) begin
				flush_pipe();
			end else if (n < 10) begin
				idle(1);
			end else begin
				rd = 5'($urandom_range(1, 15));
				send(alu_op_e'($urandom_range(0, 8)), n < 25, rd,
					5'($urandom_range(0, 15)), 5'($urandom_range(0, 15)));
			end
		end
		n = 0;
		while (exp_q.size() != 0 && n < TIMEOUT) begin
			idle(1);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("timeout: %0d write-backs never arrived", exp_q.size());
			timeout_cnt++;
		end
		idle(4);
		end_run();
	end

endmodule : tb_exec_backend

// ==== verilog/exec_backend.sv ====
`timescale 1ns/1ps

module exec_backend #(
	parameter int MDU_CYCLES = 4 // must divide 32, at least 2
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            issue_i,
	input  pipe_types_pkg::ctrl_flow_t      ctrl_flow_i,
	input  pipe_types_pkg::data_flow_t      data_flow_i,
	input  logic                            flush_i,
	output logic                            issue_ready_o,
	output logic                            reg_w_en_o,
	output logic [4:0]                      reg_w_addr_o,
	output logic [pipe_types_pkg::XLEN-1:0] reg_w_data_o
);
	import pipe_types_pkg::*;

	logic [2:0]      stall_vec;
	logic [2:0]      clr_vec;
	logic            m2_stall_req;
	logic            mdu_start;
	logic            mdu_busy;
	logic [XLEN-1:0] mdu_a;
	logic [XLEN-1:0] mdu_b;
	logic [XLEN-1:0] mdu_result;

	assign issue_ready_o = ~stall_vec[0];

	backend_pipeline #(.MDU_CYCLES(MDU_CYCLES)) u_pipe (
		.clk, .rst_n, .issue_i, .ctrl_flow_i, .data_flow_i,
		.stall_vec_i    (stall_vec),
		.clr_vec_i      (clr_vec),
		.m2_stall_req_o (m2_stall_req),
		.mdu_start_o    (mdu_start),
		.mdu_a_o        (mdu_a),
		.mdu_b_o        (mdu_b),
		.mdu_busy_i     (mdu_busy),
		.mdu_result_i   (mdu_result),
		.reg_w_en_o, .reg_w_addr_o, .reg_w_data_o
	);

	mdu #(.MDU_CYCLES(MDU_CYCLES)) u_mdu (
		.clk, .rst_n,
		.start_i (mdu_start),
		.a_i     (mdu_a),
		.b_i     (mdu_b),
		.busy_o  (mdu_busy),
		.res_o   (mdu_result)
	);

	stall_ctrl u_stall (
		.m2_stall_req_i (m2_stall_req),
		.flush_i,
		.stall_vec_o    (stall_vec),
		.clr_vec_o      (clr_vec)
	);

endmodule : exec_backend

// ==== verilog/backend_pipeline.sv ====
`timescale 1ns/1ps

module backend_pipeline #(
	parameter int MDU_CYCLES = 4
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            issue_i,
	input  pipe_types_pkg::ctrl_flow_t      ctrl_flow_i,
	input  pipe_types_pkg::data_flow_t      data_flow_i,
	input  logic [2:0]                      stall_vec_i, // ex, m1, m2
	input  logic [2:0]                      clr_vec_i,
	output logic                            m2_stall_req_o,
	output logic                            mdu_start_o,
	output logic [pipe_types_pkg::XLEN-1:0] mdu_a_o,
	output logic [pipe_types_pkg::XLEN-1:0] mdu_b_o,
	input  logic                            mdu_busy_i,
	input  logic [pipe_types_pkg::XLEN-1:0] mdu_result_i,
	output logic                            reg_w_en_o,
	output logic [4:0]                      reg_w_addr_o,
	output logic [pipe_types_pkg::XLEN-1:0] reg_w_data_o
);
	import pipe_types_pkg::*;
	import exec_ops_pkg::*;

	ctrl_flow_t ex_ctrl, m1_ctrl, m2_ctrl, wb_ctrl;
	data_flow_t ex_data, m1_data, m2_data, wb_data; // stage registers
	data_flow_t ex_fwd, m1_fwd, m2_fwd;             // operands after forwarding
	logic [1:0][XLEN-1:0] ex_opnd, m1_opnd, m2_opnd;
	logic [XLEN-1:0] alu_res;
	logic [XLEN-1:0] m2_res;

	// producer moved one stage on while the consumer was held
	function automatic fwd_info_t reaim_ex(input fwd_info_t f, input logic m1_moves,
			input logic m2_moves);
		fwd_info_t r;
		r = f;
		if ((f.ex_src[1] & m1_moves) | (f.ex_src[2] & m2_moves) | f.ex_src[3]) begin
			r.ex_src = {f.ex_src[2:1], 1'b0, ~|f.ex_src[2:1]}; // wb turns into none
			r.m1_src = {f.m1_src[1], 1'b0, ~f.m1_src[1]};
			r.m2_src = 2'b01;
		end
		return r;
	endfunction

	function automatic fwd_info_t reaim_m1(input fwd_info_t f, input logic m2_moves);
		fwd_info_t r;
		r = f;
		if ((f.m1_src[1] & m2_moves) | f.m1_src[2]) begin
			r.m1_src = {f.m1_src[1], 1'b0, ~f.m1_src[1]};
			r.m2_src = 2'b01;
		end
		return r;
	endfunction

	// forwarding sources per stage with the nearest producer at index 0
	for (genvar op = 0; op < 2; op++) begin : g_fwd
		forwarding_unit #(.SRC_NUM(3)) u_ex_fwd (
			.sel_i      (ex_ctrl.fwd[op].ex_src),
			.src_i      ({wb_data.result, m2_res, m1_data.result}),
			.old_data_i (ex_data.reg_data[op]),
			.new_data_o (ex_opnd[op])
		);
		forwarding_unit #(.SRC_NUM(2)) u_m1_fwd (
			.sel_i      (m1_ctrl.fwd[op].m1_src),
			.src_i      ({wb_data.result, m2_res}),
			.old_data_i (m1_data.reg_data[op]),
			.new_data_o (m1_opnd[op])
		);
		forwarding_unit #(.SRC_NUM(1)) u_m2_fwd (
			.sel_i      (m2_ctrl.fwd[op].m2_src),
			.src_i      (wb_data.result),
			.old_data_i (m2_data.reg_data[op]),
			.new_data_o (m2_opnd[op])
		);
	end

	alu u_alu (
		.op_i  (ex_ctrl.alu_op),
		.a_i   (ex_opnd[0]),
		.b_i   (ex_opnd[1]),
		.res_o (alu_res)
	);

	assign m2_res = (m2_ctrl.wb_sel == WB_MDU) ? mdu_result_i : m2_data.result;

	assign ex_fwd = '{pc: ex_data.pc, reg_data: ex_opnd, result: alu_res};
	assign m1_fwd = '{pc: m1_data.pc, reg_data: m1_opnd, result: m1_data.result};
	assign m2_fwd = '{pc: m2_data.pc, reg_data: m2_opnd, result: m2_res};

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			ex_ctrl <= '0;
		end else if (~stall_vec_i[0]) begin
			ex_ctrl <= issue_i ? ctrl_flow_i : '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				ex_ctrl.fwd[i] <= reaim_ex(ex_ctrl.fwd[i], ~stall_vec_i[1], ~stall_vec_i[2]);
			end
			if (clr_vec_i[0] & stall_vec_i[1]) ex_ctrl.valid <= 1'b0; // flush while held
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			m1_ctrl <= '0;
		end else if (~stall_vec_i[1]) begin
			m1_ctrl <= (clr_vec_i[0] | stall_vec_i[0]) ? '0 : ex_ctrl;
		end else begin
			for (int i = 0; i < 2; i++) begin
				m1_ctrl.fwd[i] <= reaim_m1(m1_ctrl.fwd[i], ~stall_vec_i[2]);
			end
			if (clr_vec_i[1] & stall_vec_i[2]) m1_ctrl.valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			m2_ctrl <= '0;
		end else if (~stall_vec_i[2]) begin
			m2_ctrl <= (clr_vec_i[1] | stall_vec_i[1]) ? '0 : m1_ctrl;
		end else begin
			for (int i = 0; i < 2; i++) begin
				m2_ctrl.fwd[i].m2_src <= 2'b01; // wb always retires
			end
		end
	end

	always_ff @(posedge clk) begin
		if (~rst_n) begin
			wb_ctrl <= '0;
		end else begin
			wb_ctrl <= (clr_vec_i[2] | stall_vec_i[2]) ? '0 : m2_ctrl;
		end
	end

	// held stages capture their forwarded operands
	always_ff @(posedge clk) begin
		ex_data <= stall_vec_i[0] ? ex_fwd : data_flow_i;
		m1_data <= stall_vec_i[1] ? m1_fwd : ex_fwd;
		if (stall_vec_i[2]) begin
			m2_data.reg_data <= m2_opnd;
		end else begin
			m2_data <= m1_fwd;
		end
		wb_data <= m2_fwd;
	end

	// a mul directly behind another mul, or a mul result read from m1, needs one
	// free slot after the mul since the product only exists in m2
	assign mdu_start_o = ex_ctrl.valid & ex_ctrl.mul_en & ~stall_vec_i[0] & ~clr_vec_i[0];
	assign mdu_a_o     = ex_opnd[0];
	assign mdu_b_o     = ex_opnd[1];

	assign m2_stall_req_o = m2_ctrl.valid & m2_ctrl.mul_en & mdu_busy_i;

	assign reg_w_en_o   = wb_ctrl.valid & (|wb_ctrl.w_reg);
	assign reg_w_addr_o = wb_ctrl.w_reg;
	assign reg_w_data_o = wb_data.result;

endmodule : backend_pipeline

// ==== verilog/stall_ctrl.sv ====
`timescale 1ns/1ps

module stall_ctrl (
	input  logic       m2_stall_req_i,
	input  logic       flush_i,
	output logic [2:0] stall_vec_o, // ex, m1, m2
	output logic [2:0] clr_vec_o
);
	// m2 is the only stage that asks and a held m2 holds everything behind it
	assign stall_vec_o = {3{m2_stall_req_i}};

	// bit k bubbles stage k+1
	always_comb begin
		clr_vec_o[0] = flush_i;
		clr_vec_o[1] = flush_i;
		clr_vec_o[2] = stall_vec_o[2]; // wb never stalls
	end

endmodule : stall_ctrl

// ==== verilog/mdu.sv ====
`timescale 1ns/1ps

module mdu #(
	parameter int MDU_CYCLES = 4
) (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start_i,
	input  logic [pipe_types_pkg::XLEN-1:0] a_i,
	input  logic [pipe_types_pkg::XLEN-1:0] b_i,
	output logic                            busy_o,
	output logic [pipe_types_pkg::XLEN-1:0] res_o
);
	import pipe_types_pkg::*;

	localparam int STEP = XLEN / MDU_CYCLES; // multiplier bits per cycle
	localparam int CW = $clog2(MDU_CYCLES);

	logic [XLEN-1:0] acc;
	logic [XLEN-1:0] mcand;
	logic [XLEN-1:0] mplier;
	logic [CW-1:0]   cnt;
	logic            busy;

	// partial product of one chunk of multiplier bits
	function automatic logic [XLEN-1:0] chunk_prod(input logic [XLEN-1:0] md,
			input logic [STEP-1:0] bits);
		logic [XLEN-1:0] sum;
		sum = '0;
		for (int k = 0; k < STEP; k++) begin
			if (bits[k]) sum = sum + (md << k);
		end
		return sum;
	endfunction

	// a start always reloads, so a multiply killed by flush is simply abandoned
	always_ff @(posedge clk) begin
		if (~rst_n) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (start_i) begin
			busy <= 1'b1;
			cnt  <= CW'(MDU_CYCLES - 1); // first chunk done at the start edge
		end else if (busy) begin
			cnt <= cnt - 1'b1;
			if (cnt == CW'(1)) busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start_i) begin
			acc    <= chunk_prod(a_i, b_i[STEP-1:0]);
			mcand  <= a_i << STEP;
			mplier <= b_i >> STEP;
		end else if (busy) begin
			acc    <= acc + chunk_prod(mcand, mplier[STEP-1:0]);
			mcand  <= mcand << STEP;
			mplier <= mplier >> STEP;
		end
	end

	assign busy_o = busy;
	assign res_o  = acc; // low word of the product, stays until next start

endmodule : mdu

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  exec_ops_pkg::alu_op_e           op_i,
	input  logic [pipe_types_pkg::XLEN-1:0] a_i,
	input  logic [pipe_types_pkg::XLEN-1:0] b_i,
	output logic [pipe_types_pkg::XLEN-1:0] res_o
);
	import exec_ops_pkg::*;

	logic [4:0] shamt;

	assign shamt = b_i[4:0]; // only low five bits count

	always_comb begin
		res_o = '0;
		case (op_i)
			ALU_ADD:   res_o = a_i + b_i;
			ALU_SUB:   res_o = a_i - b_i;
			ALU_AND:   res_o = a_i & b_i;
			ALU_OR:    res_o = a_i | b_i;
			ALU_XOR:   res_o = a_i ^ b_i;
			ALU_SLL:   res_o = a_i << shamt;
			ALU_SRL:   res_o = a_i >> shamt;
			ALU_SLT:   res_o[0] = $signed(a_i) < $signed(b_i);
			ALU_PASSB: res_o = b_i;
			default:   res_o = '0;
		endcase
	end

endmodule : alu

// ==== verilog/forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit #(
	parameter int SRC_NUM = 3
) (
	input  logic [SRC_NUM:0]                              sel_i,
	input  logic [SRC_NUM-1:0][pipe_types_pkg::XLEN-1:0]  src_i, // index 0 is nearest stage
	input  logic [pipe_types_pkg::XLEN-1:0]               old_data_i,
	output logic [pipe_types_pkg::XLEN-1:0]               new_data_o
);
	logic keep_old;

	// none bit, or no source picked at all
	assign keep_old = sel_i[0] | ~|sel_i[SRC_NUM:1];

	always_comb begin
		new_data_o = keep_old ? old_data_i : '0;
		for (int i = 0; i < SRC_NUM; i++) begin
			if (sel_i[i + 1]) begin
				new_data_o = new_data_o | src_i[i]; // and-or mux, sel is one-hot
			end
		end
	end

endmodule : forwarding_unit

// ==== verilog/pipe_types_pkg.sv ====
package pipe_types_pkg;
	import exec_ops_pkg::*;

	localparam int XLEN = 32;

	// forwarding selection of one operand
	// all fields one-hot, bit 0 is none
	typedef struct packed {
		logic [3:0] ex_src; // wb, m2, m1, none
		logic [2:0] m1_src; // wb, m2, none
		logic [1:0] m2_src; // wb, none
	} fwd_info_t;

	// control of one instruction
	typedef struct packed {
		logic           valid;
		alu_op_e        alu_op;
		wb_sel_e        wb_sel;
		logic           mul_en;
		logic [4:0]     w_reg; // zero means no write
		fwd_info_t [1:0] fwd;  // one per operand
	} ctrl_flow_t;

	// data of one instruction
	typedef struct packed {
		logic [XLEN-1:0]       pc;
		logic [1:0][XLEN-1:0]  reg_data; // operands from register read
		logic [XLEN-1:0]       result;
	} data_flow_t;

endpackage : pipe_types_pkg

// ==== verilog/exec_ops_pkg.sv ====
package exec_ops_pkg;

	// ALU operation of the ex stage
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SLL   = 4'd5,
		ALU_SRL   = 4'd6,
		ALU_SLT   = 4'd7, // signed compare
		ALU_PASSB = 4'd8
	} alu_op_e;

	// where the stage result comes from in m2
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MDU = 1'b1
	} wb_sel_e;

endpackage : exec_ops_pkg
